/* logic/epd_caster.sv */
`timescale 1ns/1ps

module epd_caster (
    input  logic                                             clk,
    input  logic                                             rst,
    // Image input, four Y8 pixels per clock
    input  logic                                             vin_vsync,
    input  logic [epd_pkg::Y8_W*epd_pkg::NUM_LANES-1:0]      vin_pixel,
    input  logic                                             vin_valid,
    output logic                                             vin_ready,
    // Framebuffer state in and writeback
    input  logic [epd_pkg::STATE_W*epd_pkg::NUM_LANES-1:0]   bi_pixel,
    input  logic                                             bi_valid,
    output logic                                             bi_ready,
    output logic [epd_pkg::STATE_W*epd_pkg::NUM_LANES-1:0]   bo_pixel,
    output logic                                             bo_valid,
    // Configuration, stable while idle
    input  epd_pkg::timing_cfg_t                             cfg,
    input  logic [epd_pkg::FCNT_W-1:0]                       lut_frames,
    input  logic                                             lut_we,
    input  logic [epd_pkg::LUT_ADDR_W-1:0]                   lut_addr,
    input  logic [epd_pkg::LUT_DATA_W-1:0]                   lut_data,
    // Panel
    output logic                                             epd_gdclk,
    output logic                                             epd_gdsp,
    output logic                                             epd_sdle,
    output logic                                             epd_sdce0,
    output logic [epd_pkg::DRIVE_W*epd_pkg::NUM_LANES-1:0]   epd_sd,
    // Status
    output logic                                             b_trigger,
    input  logic                                             sys_ready,
    input  logic                                             global_en
);
    import epd_pkg::*;

    logic ready_window;
    logic frame_start;
    logic in_active;
    logic lanes_valid;
    logic kill;
    lane_in_t  [NUM_LANES-1:0] lanes;
    lane_out_t [NUM_LANES-1:0] results;

    scan_timing scan_timing_i (
        .clk          (clk),
        .rst          (rst),
        .sys_ready    (sys_ready),
        .global_en    (global_en),
        .vin_vsync    (vin_vsync),
        .cfg          (cfg),
        .ready_window (ready_window),
        .frame_start  (frame_start),
        .in_active    (in_active),
        .epd_gdclk    (epd_gdclk),
        .epd_gdsp     (epd_gdsp),
        .epd_sdle     (epd_sdle),
        .b_trigger    (b_trigger)
    );

    // Source chip enable is active low over the active region
    assign epd_sdce0 = ~in_active;

    pixel_feed pixel_feed_i (
        .clk          (clk),
        .rst          (rst),
        .ready_window (ready_window),
        .frame_start  (frame_start),
        .vin_pixel    (vin_pixel),
        .vin_valid    (vin_valid),
        .bi_pixel     (bi_pixel),
        .bi_valid     (bi_valid),
        .vin_ready    (vin_ready),
        .bi_ready     (bi_ready),
        .lanes        (lanes),
        .lanes_valid  (lanes_valid),
        .kill         (kill)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        waveform_lane waveform_lane_i (
            .clk        (clk),
            .lut_frames (lut_frames),
            .lut_we     (lut_we),
            .lut_addr   (lut_addr),
            .lut_data   (lut_data),
            .lane       (lanes[i]),
            .result     (results[i])
        );
    end

    source_output source_output_i (
        .clk           (clk),
        .rst           (rst),
        .results       (results),
        .results_valid (lanes_valid),
        .kill          (kill),
        .epd_sd        (epd_sd),
        .bo_pixel      (bo_pixel),
        .bo_valid      (bo_valid)
    );

endmodule

/* logic/epd_pkg.sv */
package epd_pkg;

    // Datapath geometry
    localparam int NUM_LANES = 4;
    localparam int STATE_W = 16;
    localparam int Y8_W = 8;
    localparam int GREY_W = 4;
    localparam int FCNT_W = 6;
    localparam int DRIVE_W = 2;

    // Waveform table write port, four 2-bit entries per word
    localparam int LUT_ADDR_W = 12;
    localparam int LUT_DATA_W = 8;
    localparam int LUT_DEPTH = 1 << LUT_ADDR_W;

    // Scan timing
    localparam int VS_DELAY = 8;
    localparam int PIPELINE_DELAY = 4;
    localparam int CNT_W = 11;

    // Frame geometry, vertical in lines, horizontal in clocks of 4 pixels
    typedef struct packed {
        logic [7:0]  vfp;
        logic [7:0]  vsync;
        logic [7:0]  vbp;
        logic [11:0] vact;
        logic [7:0]  hfp;
        logic [7:0]  hsync;
        logic [7:0]  hbp;
        logic [11:0] hact;
    } timing_cfg_t;

    // Framebuffer state word
    typedef struct packed {
        logic [1:0]        spare;
        logic [GREY_W-1:0] src;
        logic [FCNT_W-1:0] fcnt;
        logic [GREY_W-1:0] tgt;
    } pixel_state_t;

    typedef enum logic [1:0] {
        SCAN_IDLE    = 2'd0,
        SCAN_WAITING = 2'd1,
        SCAN_RUNNING = 2'd2
    } scan_state_t;

    // Source driver codes
    typedef enum logic [DRIVE_W-1:0] {
        DRV_HOLD     = 2'b00,
        DRV_BLACK    = 2'b01,
        DRV_WHITE    = 2'b10,
        DRV_HOLD_ALT = 2'b11
    } drive_t;

    typedef struct packed {
        logic [GREY_W-1:0] y4;
        pixel_state_t      state;
    } lane_in_t;

    typedef struct packed {
        drive_t       drive;
        pixel_state_t new_state;
        pixel_state_t old_state;
    } lane_out_t;

endpackage

/* logic/pixel_feed.sv */
`timescale 1ns/1ps

module pixel_feed (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             ready_window,
    input  logic                                             frame_start,
    input  logic [epd_pkg::Y8_W*epd_pkg::NUM_LANES-1:0]      vin_pixel,
    input  logic                                             vin_valid,
    input  logic [epd_pkg::STATE_W*epd_pkg::NUM_LANES-1:0]   bi_pixel,
    input  logic                                             bi_valid,
    output logic                                             vin_ready,
    output logic                                             bi_ready,
    output epd_pkg::lane_in_t [epd_pkg::NUM_LANES-1:0]       lanes,
    output logic                                             lanes_valid,
    output logic                                             kill
);
    import epd_pkg::*;

    // High in the cycle the FIFO data for last cycle's ready shows up
    logic fetch_d;
    logic underrun;
    lane_in_t [NUM_LANES-1:0] lanes_next;

    assign vin_ready = ready_window;
    assign bi_ready  = ready_window;

    // Both sources readied and neither delivered
    assign underrun = fetch_d && !vin_valid && !bi_valid;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            // Upper nibble of each Y8 byte
            lanes_next[i].y4    = vin_pixel[i*Y8_W + (Y8_W - GREY_W) +: GREY_W];
            lanes_next[i].state = bi_pixel[i*STATE_W +: STATE_W];
        end
    end

    always_ff @(posedge clk) begin
        lanes <= lanes_next;
    end

    // kill flips in the same cycle the failed word reaches the lanes
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_d     <= 1'b0;
            lanes_valid <= 1'b0;
            kill        <= 1'b0;
        end else begin
            fetch_d     <= ready_window;
            lanes_valid <= fetch_d;
            if (frame_start) begin
                kill <= 1'b0;
            end else if (underrun) begin
                kill <= 1'b1;
            end
        end
    end

endmodule

/* logic/scan_timing.sv */
`timescale 1ns/1ps

module scan_timing (
    input  logic                clk,
    input  logic                rst,
    input  logic                sys_ready,
    input  logic                global_en,
    input  logic                vin_vsync,
    input  epd_pkg::timing_cfg_t cfg,
    output logic                ready_window,
    output logic                frame_start,
    output logic                in_active,
    output logic                epd_gdclk,
    output logic                epd_gdsp,
    output logic                epd_sdle,
    output logic                b_trigger
);
    import epd_pkg::*;

    scan_state_t state;
    logic [CNT_W-1:0] h_cnt;
    logic [CNT_W-1:0] v_cnt;

    // Region boundaries derived from the configuration
    logic [CNT_W-1:0] v_sync_start;
    logic [CNT_W-1:0] v_bp_start;
    logic [CNT_W-1:0] v_act_start;
    logic [CNT_W-1:0] v_total;
    logic [CNT_W-1:0] h_sync_start;
    logic [CNT_W-1:0] h_bp_start;
    logic [CNT_W-1:0] h_act_start;
    logic [CNT_W-1:0] h_total;

    logic running;
    logic wait_done;
    logic line_end;
    logic last_line;
    logic in_vsync;
    logic in_vact;
    logic in_hsync;
    logic in_hbp;
    logic in_hact;
    logic early_hact;
    logic gdclk_pre;

    always_comb begin
        v_sync_start = CNT_W'(cfg.vfp);
        v_bp_start   = v_sync_start + CNT_W'(cfg.vsync);
        v_act_start  = v_bp_start + CNT_W'(cfg.vbp);
        v_total      = v_act_start + CNT_W'(cfg.vact);
        h_sync_start = CNT_W'(cfg.hfp);
        h_bp_start   = h_sync_start + CNT_W'(cfg.hsync);
        h_act_start  = h_bp_start + CNT_W'(cfg.hbp);
        h_total      = h_act_start + CNT_W'(cfg.hact);
    end

    assign running   = (state == SCAN_RUNNING);
    assign wait_done = (state == SCAN_WAITING) && (h_cnt == CNT_W'(VS_DELAY));
    assign line_end  = (h_cnt == h_total - 1'b1);
    assign last_line = (v_cnt == v_total - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && global_en && vin_vsync) begin
                        state <= SCAN_WAITING;
                    end
                end
                SCAN_WAITING: begin
                    // h_cnt doubles as the post-sync delay counter
                    if (wait_done) begin
                        state <= SCAN_RUNNING;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                SCAN_RUNNING: begin
                    if (line_end) begin
                        h_cnt <= '0;
                        if (last_line) begin
                            state <= SCAN_IDLE;
                            v_cnt <= '0;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // Region decode, only meaningful while the frame runs
    assign in_vsync = running && (v_cnt >= v_sync_start) && (v_cnt < v_bp_start);
    assign in_vact  = running && (v_cnt >= v_act_start);
    assign in_hsync = running && (h_cnt >= h_sync_start) && (h_cnt < h_bp_start);
    assign in_hbp   = running && (h_cnt >= h_bp_start) && (h_cnt < h_act_start);
    assign in_hact  = running && (h_cnt >= h_act_start);

    // Same window as hact, opened early to cover the pixel pipeline
    assign early_hact = running
        && (h_cnt >= h_act_start - CNT_W'(PIPELINE_DELAY))
        && (h_cnt < h_total - CNT_W'(PIPELINE_DELAY));

    assign in_active    = in_vact && in_hact;
    assign ready_window = in_vact && early_hact;
    assign frame_start  = wait_done;
    assign b_trigger    = (state == SCAN_WAITING);

    // Gate driver clock, one cycle behind the scan position
    assign gdclk_pre = in_hsync || in_hbp || in_hact;

    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
        end else begin
            epd_gdclk <= gdclk_pre;
        end
    end

    assign epd_gdsp = ~in_vsync;
    assign epd_sdle = in_hsync;

endmodule

/* logic/source_output.sv */
`timescale 1ns/1ps

module source_output (
    input  logic                                             clk,
    input  logic                                             rst,
    input  epd_pkg::lane_out_t [epd_pkg::NUM_LANES-1:0]      results,
    input  logic                                             results_valid,
    input  logic                                             kill,
    output logic [epd_pkg::DRIVE_W*epd_pkg::NUM_LANES-1:0]   epd_sd,
    output logic [epd_pkg::STATE_W*epd_pkg::NUM_LANES-1:0]   bo_pixel,
    output logic                                             bo_valid
);
    import epd_pkg::*;

    // Valid and kill arrive with the lane inputs, one cycle before results
    logic valid_q;
    logic kill_q;
    logic [DRIVE_W*NUM_LANES-1:0] sd_next;
    logic [STATE_W*NUM_LANES-1:0] wb_next;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            // Blanked frame drives nothing and keeps the old state
            sd_next[i*DRIVE_W +: DRIVE_W] = kill_q ? DRV_HOLD : results[i].drive;
            wb_next[i*STATE_W +: STATE_W] = kill_q ? results[i].old_state
                                                   : results[i].new_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= 1'b0;
            kill_q   <= 1'b0;
            bo_valid <= 1'b0;
            epd_sd   <= '0;
        end else begin
            valid_q  <= results_valid;
            kill_q   <= kill;
            bo_valid <= valid_q;
            // Source bus idles at zero between active words
            epd_sd   <= valid_q ? sd_next : '0;
        end
    end

    always_ff @(posedge clk) begin
        bo_pixel <= wb_next;
    end

endmodule

/* logic/waveform_lane.sv */
`timescale 1ns/1ps

module waveform_lane (
    input  logic                            clk,
    input  logic [epd_pkg::FCNT_W-1:0]      lut_frames,
    input  logic                            lut_we,
    input  logic [epd_pkg::LUT_ADDR_W-1:0]  lut_addr,
    input  logic [epd_pkg::LUT_DATA_W-1:0]  lut_data,
    input  epd_pkg::lane_in_t               lane,
    output epd_pkg::lane_out_t              result
);
    import epd_pkg::*;

    // One table copy per lane so all lanes look up in parallel
    logic [LUT_DATA_W-1:0] lut_mem [LUT_DEPTH];

    pixel_state_t          cur;
    pixel_state_t          next_state;
    logic                  in_transition;
    logic [FCNT_W-1:0]     fseq;
    logic [LUT_ADDR_W-1:0] rd_addr;

    // Lookup stage registers
    logic [LUT_DATA_W-1:0] rd_word;
    logic [1:0]            slot_q;
    logic                  in_transition_q;
    pixel_state_t          new_q;
    pixel_state_t          old_q;
    logic [DRIVE_W-1:0]    entry;

    assign cur           = lane.state;
    assign in_transition = (cur.fcnt != '0);

    // fcnt counts down, so the sequence index counts up from 0
    assign fseq    = lut_frames - cur.fcnt;
    assign rd_addr = {fseq, cur.tgt, cur.src[3:2]};

    always_comb begin
        next_state = cur;
        if (in_transition) begin
            next_state.fcnt = cur.fcnt - 1'b1;
        end else if (lane.y4 != cur.tgt) begin
            // New target, start a fresh transition from the old one
            next_state.src  = cur.tgt;
            next_state.tgt  = lane.y4;
            next_state.fcnt = lut_frames;
        end
    end

    always_ff @(posedge clk) begin
        if (lut_we) begin
            lut_mem[lut_addr] <= lut_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_word         <= lut_mem[rd_addr];
        slot_q          <= cur.src[1:0];
        in_transition_q <= in_transition;
        new_q           <= next_state;
        old_q           <= cur;
    end

    // Pick the 2-bit entry out of the four in the word
    assign entry = rd_word[{slot_q, 1'b0} +: DRIVE_W];

    always_comb begin
        result.drive     = in_transition_q ? drive_t'(entry) : DRV_HOLD;
        result.new_state = new_q;
        result.old_state = old_q;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f sources.f --top-module tb_epd_caster -o sim_epd \
    && ./obj_dir/sim_epd | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* sources.f */
logic/epd_pkg.sv
logic/scan_timing.sv
logic/pixel_feed.sv
logic/waveform_lane.sv
logic/source_output.sv
logic/epd_caster.sv
testbench/epd_checker.sv
testbench/tb_epd_caster.sv

/* testbench/epd_checker.sv */
`timescale 1ns/1ps

module epd_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  epd_pkg::timing_cfg_t cfg,
    input  logic [5:0]           lut_frames,
    input  logic                 lut_we,
    input  logic [11:0]          lut_addr,
    input  logic [7:0]           lut_data,
    input  logic [31:0]          vin_pixel,
    input  logic                 vin_valid,
    input  logic                 vin_ready,
    input  logic [63:0]          bi_pixel,
    input  logic                 bi_valid,
    input  logic                 bi_ready,
    input  logic                 b_trigger,
    input  logic                 epd_gdclk,
    input  logic                 epd_gdsp,
    input  logic                 epd_sdle,
    input  logic                 epd_sdce0,
    input  logic [7:0]           epd_sd,
    input  logic [63:0]          bo_pixel,
    input  logic                 bo_valid,
    input  logic                 test_done,
    input  int                   test_frames,
    output int                   error_count,
    output int                   test_count
);
    import epd_pkg::*;

    logic [7:0]  lut_model [LUT_DEPTH];
    logic [63:0] exp_wb [$];
    logic [7:0]  exp_sd [$];
    int          exp_due [$];
    int          cyc = 0;
    int          errs_at_start = 0;
    logic        ready_prev = 1'b0;
    logic        kill_m = 1'b0;
    int          n_trig = 0;
    int          n_act = 0;
    int          n_rdy = 0;
    int          n_gdsp = 0;
    int          n_sdle = 0;
    int          n_gdclk = 0;

    // Lane rule steps an ongoing transition or starts one on a new target
    task automatic apply_lane(input logic [15:0] st, input logic [3:0] y4, input logic killed,
                              output logic [15:0] wb, output logic [1:0] drv);
        logic [3:0] src;
        logic [5:0] fcnt;
        logic [3:0] tgt;
        logic [5:0] fseq;
        logic [7:0] word;
        src = st[13:10];
        fcnt = st[9:4];
        tgt = st[3:0];
        wb = st;
        drv = 2'b00;
        if (fcnt != 6'd0) begin
            fseq = lut_frames - fcnt;
            word = lut_model[{fseq, tgt, src[3:2]}];
            drv = word[{src[1:0], 1'b0} +: 2];
            wb[9:4] = fcnt - 6'd1;
        end else if (y4 != tgt) begin
            wb[13:10] = tgt;
            wb[3:0] = y4;
            wb[9:4] = lut_frames;
        end
        if (killed) begin
            wb = st;
            drv = 2'b00;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        logic [63:0] wb_word;
        logic [7:0]  sd_word;
        logic [15:0] wb_lane;
        logic [1:0]  drv_lane;
        int          htot;
        int          vtot;
        if (lut_we) begin
            lut_model[lut_addr] = lut_data;
        end
        if (rst) begin
            error_count = 0;
            test_count = 0;
        end else begin
            if (vin_ready != bi_ready) begin
                $display("The two ready strobes disagree at cycle %0d", cyc);
                error_count++;
            end
            // Output side is checked first against words queued in earlier cycles
            if (exp_due.size() > 0 && exp_due[0] == cyc) begin
                if (!bo_valid) begin
                    $display("bo_valid missing at cycle %0d", cyc);
                    error_count++;
                end else if (bo_pixel != exp_wb[0]) begin
                    $display("ERR bo_pixel: got %h expected %h", bo_pixel, exp_wb[0]);
                    error_count++;
                end
                if (epd_sd != exp_sd[0]) begin
                    $display("ERR epd_sd: got %h expected %h", epd_sd, exp_sd[0]);
                    error_count++;
                end
                // Source data must sit inside the chip enable window
                if (epd_sdce0) begin
                    $display("ERR epd_sdce0: got %h expected %h", epd_sdce0, 1'b0);
                    error_count++;
                end
                void'(exp_due.pop_front());
                void'(exp_wb.pop_front());
                void'(exp_sd.pop_front());
            end else begin
                if (bo_valid) begin
                    $display("Unexpected bo_valid at cycle %0d", cyc);
                    error_count++;
                end
                if (epd_sd != 8'h00) begin
                    $display("ERR epd_sd: got %h expected %h", epd_sd, 8'h00);
                    error_count++;
                end
            end
            // Data cycle follows a ready by one cycle
            if (b_trigger) begin
                kill_m = 1'b0;
            end
            if (ready_prev) begin
                if (!vin_valid && !bi_valid) begin
                    kill_m = 1'b1;
                end
                for (int i = 0; i < 4; i++) begin
                    apply_lane(bi_pixel[i*16 +: 16], vin_pixel[i*8+4 +: 4], kill_m,
                               wb_lane, drv_lane);
                    wb_word[i*16 +: 16] = wb_lane;
                    sd_word[i*2 +: 2] = drv_lane;
                end
                exp_wb.push_back(wb_word);
                exp_sd.push_back(sd_word);
                exp_due.push_back(cyc + 3);
            end
            ready_prev = vin_ready;
            n_trig += int'(b_trigger);
            n_act += int'(!epd_sdce0);
            n_rdy += int'(vin_ready);
            n_gdsp += int'(!epd_gdsp);
            n_sdle += int'(epd_sdle);
            n_gdclk += int'(epd_gdclk);
            if (test_done) begin
                htot = int'(cfg.hfp) + int'(cfg.hsync) + int'(cfg.hbp) + int'(cfg.hact);
                vtot = int'(cfg.vfp) + int'(cfg.vsync) + int'(cfg.vbp) + int'(cfg.vact);
                check_count("b_trigger cycles", n_trig, test_frames * (VS_DELAY + 1));
                check_count("sdce0 low cycles", n_act,
                            test_frames * int'(cfg.vact) * int'(cfg.hact));
                check_count("ready cycles", n_rdy, test_frames * int'(cfg.vact) * int'(cfg.hact));
                check_count("gdsp low cycles", n_gdsp, test_frames * int'(cfg.vsync) * htot);
                check_count("sdle high cycles", n_sdle, test_frames * int'(cfg.hsync) * vtot);
                check_count("gdclk high cycles", n_gdclk, test_frames * vtot
                            * (int'(cfg.hsync) + int'(cfg.hbp) + int'(cfg.hact)));
                if (exp_due.size() != 0) begin
                    $display("Words still pending at the end of test %0d", test_count + 1);
                    error_count++;
                end
                test_count++;
                $display("test %0d: %0d frame(s), %0d error(s)", test_count, test_frames,
                         error_count - errs_at_start);
                errs_at_start = error_count;
                n_trig = 0;
                n_act = 0;
                n_rdy = 0;
                n_gdsp = 0;
                n_sdle = 0;
                n_gdclk = 0;
            end
        end
        cyc++;
    end

endmodule

/* testbench/tb_epd_caster.sv */
`timescale 1ns/1ps

module tb_epd_caster;
    import epd_pkg::*;

    // Small test geometry
    localparam int HFP = 2;
    localparam int HSYNC = 2;
    localparam int HBP = 2;
    localparam int HACT = 8;
    localparam int VFP = 1;
    localparam int VSYNC = 1;
    localparam int VBP = 1;
    localparam int VACT = 4;
    localparam int WORDS = HACT * VACT;
    localparam int FRAME_CYCLES = VS_DELAY + 1
        + (HFP + HSYNC + HBP + HACT) * (VFP + VSYNC + VBP + VACT);
    localparam int NUM_FRAMES = 6;
    localparam int DROP_FRAME = 3;
    localparam int DROP_WORD = 10;
    localparam int IDLE_CYCLES = 30;
    localparam int TIMEOUT = LUT_DEPTH + (NUM_FRAMES + 1) * (FRAME_CYCLES + IDLE_CYCLES) + 200;

    logic clk = 1'b0;
    logic rst;
    logic vin_vsync;
    logic [31:0] vin_pixel = '0;
    logic vin_valid = 1'b1;
    logic vin_ready;
    logic [63:0] bi_pixel = '0;
    logic bi_valid = 1'b1;
    logic bi_ready;
    logic [63:0] bo_pixel;
    logic bo_valid;
    timing_cfg_t cfg;
    logic [5:0] lut_frames;
    logic lut_we;
    logic [11:0] lut_addr;
    logic [7:0] lut_data;
    logic epd_gdclk;
    logic epd_gdsp;
    logic epd_sdle;
    logic epd_sdce0;
    logic b_trigger;
    logic [7:0] epd_sd;
    logic sys_ready;
    logic global_en;
    logic test_done;
    int test_frames;
    int error_count;
    int test_count;

    // Framebuffer model and its read and write pointers
    logic [63:0] fb [WORDS];
    int rd_idx = 0;
    int wr_idx = 0;
    logic fetch_pending = 1'b0;
    logic drop_en;
    int cycles = 0;

    always #10 clk = ~clk;

    epd_caster epd_caster_i (
        .clk(clk), .rst(rst), .vin_vsync(vin_vsync), .vin_pixel(vin_pixel),
        .vin_valid(vin_valid), .vin_ready(vin_ready), .bi_pixel(bi_pixel),
        .bi_valid(bi_valid), .bi_ready(bi_ready), .bo_pixel(bo_pixel), .bo_valid(bo_valid),
        .cfg(cfg), .lut_frames(lut_frames), .lut_we(lut_we), .lut_addr(lut_addr),
        .lut_data(lut_data), .epd_gdclk(epd_gdclk), .epd_gdsp(epd_gdsp),
        .epd_sdle(epd_sdle), .epd_sdce0(epd_sdce0), .epd_sd(epd_sd),
        .b_trigger(b_trigger), .sys_ready(sys_ready), .global_en(global_en)
    );

    epd_checker checker_i (
        .clk(clk), .rst(rst), .cfg(cfg), .lut_frames(lut_frames), .lut_we(lut_we),
        .lut_addr(lut_addr), .lut_data(lut_data), .vin_pixel(vin_pixel),
        .vin_valid(vin_valid), .vin_ready(vin_ready), .bi_pixel(bi_pixel),
        .bi_valid(bi_valid), .bi_ready(bi_ready), .b_trigger(b_trigger),
        .epd_gdclk(epd_gdclk), .epd_gdsp(epd_gdsp), .epd_sdle(epd_sdle),
        .epd_sdce0(epd_sdce0), .epd_sd(epd_sd), .bo_pixel(bo_pixel), .bo_valid(bo_valid),
        .test_done(test_done), .test_frames(test_frames),
        .error_count(error_count), .test_count(test_count)
    );

    // FIFO side presents each word one cycle after its ready
    always @(negedge clk) begin
        if (b_trigger) begin
            rd_idx = 0;
        end
        if (fetch_pending) begin
            vin_pixel = $urandom;
            bi_pixel = fb[rd_idx];
            vin_valid = !(drop_en && rd_idx == DROP_WORD);
            bi_valid = vin_valid;
            rd_idx = rd_idx + 1;
        end else begin
            vin_valid = 1'b1;
            bi_valid = 1'b1;
        end
        fetch_pending = vin_ready;
    end

    // Writeback into the framebuffer model
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WORDS; i++) begin
                fb[i] = '0;
            end
        end else begin
            if (b_trigger) begin
                wr_idx = 0;
            end
            if (bo_valid && wr_idx < WORDS) begin
                fb[wr_idx] = bo_pixel;
                wr_idx = wr_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic pulse_vsync();
        @(negedge clk);
        vin_vsync = 1'b1;
        @(negedge clk);
        vin_vsync = 1'b0;
    endtask

    task automatic end_test(input int frames);
        test_frames = frames;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    task automatic run_frame(input logic drop);
        drop_en = drop;
        pulse_vsync();
        while (!b_trigger) @(negedge clk);
        while (b_trigger) @(negedge clk);
        while (wr_idx < WORDS) @(negedge clk);
        // Let the delayed gate clock settle into idle
        repeat (2) @(negedge clk);
        drop_en = 1'b0;
        end_test(1);
    endtask

    initial begin
        void'($urandom(32200));
        rst = 1'b1;
        vin_vsync = 1'b0;
        sys_ready = 1'b1;
        global_en = 1'b0;
        lut_we = 1'b0;
        lut_addr = '0;
        lut_data = '0;
        lut_frames = 6'd3;
        drop_en = 1'b0;
        test_done = 1'b0;
        test_frames = 0;
        cfg.vfp = 8'(VFP);
        cfg.vsync = 8'(VSYNC);
        cfg.vbp = 8'(VBP);
        cfg.vact = 12'(VACT);
        cfg.hfp = 8'(HFP);
        cfg.hsync = 8'(HSYNC);
        cfg.hbp = 8'(HBP);
        cfg.hact = 12'(HACT);
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int a = 0; a < LUT_DEPTH; a++) begin
            @(negedge clk);
            lut_we = 1'b1;
            lut_addr = 12'(a);
            lut_data = 8'($urandom);
        end
        @(negedge clk);
        lut_we = 1'b0;
        // Disabled controller must ignore vsync
        pulse_vsync();
        repeat (IDLE_CYCLES) @(negedge clk);
        end_test(0);
        global_en = 1'b1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f == DROP_FRAME);
            repeat (5) @(negedge clk);
        end
        @(negedge clk);
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
